// File: hdl/ex_pkg.sv
package ex_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CNT_W      = 16;

    // csr map, byte addresses on the apb port
    localparam logic [7:0] CSR_CTRL     = 8'h00;
    localparam logic [7:0] CSR_OV_CNT   = 8'h04; // read only
    localparam logic [7:0] CSR_TRAP_CNT = 8'h08; // read only
    localparam logic [7:0] CSR_CLR      = 8'h0C; // write only
    localparam logic [1:0] CSR_CTRL_RST = 2'b11; // both exceptions enabled

    // alu operation codes, mips style numbering
    typedef enum logic [7:0] {
        OP_NOP   = 8'h00,
        OP_SRL   = 8'h02,
        OP_SRA   = 8'h03,
        OP_MFHI  = 8'h10,
        OP_MTHI  = 8'h11,
        OP_MFLO  = 8'h12,
        OP_MTLO  = 8'h13,
        OP_MULT  = 8'h18,
        OP_MULTU = 8'h19,
        OP_ADD   = 8'h20,
        OP_ADDU  = 8'h21,
        OP_SUB   = 8'h22,
        OP_SUBU  = 8'h23,
        OP_AND   = 8'h24,
        OP_OR    = 8'h25,
        OP_XOR   = 8'h26,
        OP_NOR   = 8'h27,
        OP_SLT   = 8'h2A,
        OP_SLTU  = 8'h2B,
        OP_TGE   = 8'h30,
        OP_TGEU  = 8'h31,
        OP_TLT   = 8'h32,
        OP_TLTU  = 8'h33,
        OP_TEQ   = 8'h34,
        OP_TNE   = 8'h36,
        OP_TGEI  = 8'h44,
        OP_TGEIU = 8'h45,
        OP_TLTI  = 8'h46,
        OP_TLTIU = 8'h47,
        OP_TEQI  = 8'h48,
        OP_TNEI  = 8'h49,
        OP_ADDI  = 8'h55,
        OP_ADDIU = 8'h56,
        OP_SLL   = 8'h7C,
        OP_CLZ   = 8'hB0,
        OP_CLO   = 8'hB1
    } aluop_e;

    // result class
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100
    } alusel_e;

    typedef struct packed {
        aluop_e                aluop;
        alusel_e               alusel;
        logic [DATA_W-1:0]     reg1;
        logic [DATA_W-1:0]     reg2;   // already sign extended for immediate forms
        logic [REG_ADDR_W-1:0] wd;
        logic                  wreg;
    } ex_issue_t;

    typedef struct packed {
        logic [DATA_W-1:0] hi;
        logic [DATA_W-1:0] lo;
    } hilo_hl_t;

    // product view from mult, hi/lo view for the register and mthi/mtlo
    typedef union packed {
        logic [2*DATA_W-1:0] prod;
        hilo_hl_t            hl;
    } hilo_u;

    typedef struct packed {
        logic  we;
        hilo_u val;
    } hilo_wr_t;

    // bit order matches CSR_CLR and the enable bits
    typedef struct packed {
        logic trap;
        logic ov;
    } exc_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] wd;
        logic                  wreg;
        logic [DATA_W-1:0]     wdata;
        exc_t                  exc;
    } ex_result_t;

    // one pipeline stage as held by mem and wb
    typedef struct packed {
        ex_result_t res;
        hilo_wr_t   hilo;
    } ex_stage_t;

    typedef struct packed {
        logic trap_en; // bit 1
        logic ov_en;   // bit 0
    } ex_cfg_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [7:0]        paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage

// File: hdl/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::ex_issue_t         issue_i,
    input  ex_pkg::ex_cfg_t           cfg_i,
    output logic [ex_pkg::DATA_W-1:0] wdata_o,
    output logic                      wreg_o,
    output ex_pkg::exc_t              exc_o
);
    import ex_pkg::*;

    logic [DATA_W-1:0] reg1;
    logic [DATA_W-1:0] reg2;
    logic [DATA_W-1:0] reg2_mux;  // reg2 or its two's complement
    logic [DATA_W-1:0] sum;
    logic              signed_cmp;
    logic              sub_op;
    logic              ov_sum;
    logic              lt;
    logic              eq;
    logic              trap_hit;
    logic              ov_hit;
    logic [5:0]        clz_cnt;
    logic [5:0]        clo_cnt;
    logic [DATA_W-1:0] logic_res;
    logic [DATA_W-1:0] shift_res;
    logic [DATA_W-1:0] arith_res;

    // count of zeros above the first one or DATA_W when none
    function automatic logic [5:0] lead_zeros(input logic [DATA_W-1:0] val);
        logic [5:0] cnt;
        logic       hit;
        cnt = 6'd0;
        hit = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (val[i]) begin
                hit = 1'b1;
            end else if (!hit) begin
                cnt = cnt + 6'd1;
            end
        end
        return cnt;
    endfunction

    assign reg1 = issue_i.reg1;
    assign reg2 = issue_i.reg2;

    assign signed_cmp = issue_i.aluop inside {OP_SLT, OP_TLT, OP_TLTI, OP_TGE, OP_TGEI};
    assign sub_op     = signed_cmp || (issue_i.aluop inside {OP_SUB, OP_SUBU});

    assign reg2_mux = sub_op ? (~reg2 + 1'b1) : reg2;
    assign sum      = reg1 + reg2_mux;

    // equal effective operand signs but the sum flips sign
    assign ov_sum = (reg1[DATA_W-1] == (reg2[DATA_W-1] ^ sub_op)) &&
                    (sum[DATA_W-1] != reg1[DATA_W-1]);

    // signed less-than from the operand signs and the sign of the difference
    assign lt = signed_cmp ?
                ((reg1[DATA_W-1] && !reg2[DATA_W-1]) ||
                 (!reg1[DATA_W-1] && !reg2[DATA_W-1] && sum[DATA_W-1]) ||
                 (reg1[DATA_W-1] && reg2[DATA_W-1] && sum[DATA_W-1])) :
                (reg1 < reg2);
    assign eq = (reg1 == reg2);

    assign clz_cnt = lead_zeros(reg1);
    assign clo_cnt = lead_zeros(~reg1);   // leading ones as zeros of the inverse

    always_comb begin
        case (issue_i.aluop)
            OP_OR:   logic_res = reg1 | reg2;
            OP_AND:  logic_res = reg1 & reg2;
            OP_NOR:  logic_res = ~(reg1 | reg2);
            OP_XOR:  logic_res = reg1 ^ reg2;
            default: logic_res = '0;
        endcase
    end

    // shift amount in reg1 and value in reg2
    always_comb begin
        case (issue_i.aluop)
            OP_SLL:  shift_res = reg2 << reg1[4:0];
            OP_SRL:  shift_res = reg2 >> reg1[4:0];
            OP_SRA:  shift_res = $signed(reg2) >>> reg1[4:0]; // sign fill
            default: shift_res = '0;
        endcase
    end

    always_comb begin
        case (issue_i.aluop)
            OP_SLT, OP_SLTU: begin
                arith_res = {{(DATA_W-1){1'b0}}, lt};
            end
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU, OP_SUB, OP_SUBU: begin
                arith_res = sum;
            end
            OP_CLZ:  arith_res = {{(DATA_W-6){1'b0}}, clz_cnt};
            OP_CLO:  arith_res = {{(DATA_W-6){1'b0}}, clo_cnt};
            default: arith_res = '0;
        endcase
    end

    always_comb begin
        case (issue_i.aluop)
            OP_TEQ, OP_TEQI:                    trap_hit = eq;
            OP_TNE, OP_TNEI:                    trap_hit = !eq;
            OP_TGE, OP_TGEI, OP_TGEU, OP_TGEIU: trap_hit = !lt;
            OP_TLT, OP_TLTI, OP_TLTU, OP_TLTIU: trap_hit = lt;
            default:                            trap_hit = 1'b0;
        endcase
    end

    // only the trapping adds and sub raise overflow
    assign ov_hit = ov_sum && (issue_i.aluop inside {OP_ADD, OP_ADDI, OP_SUB});

    assign exc_o.ov   = ov_hit && cfg_i.ov_en;
    assign exc_o.trap = trap_hit && cfg_i.trap_en;
    assign wreg_o     = issue_i.wreg && !exc_o.ov;   // disabled ov keeps the wrapped write

    always_comb begin
        case (issue_i.alusel)
            SEL_LOGIC: wdata_o = logic_res;
            SEL_SHIFT: wdata_o = shift_res;
            SEL_ARITH: wdata_o = arith_res;
            default:   wdata_o = '0;     // move data comes from the hi/lo unit
        endcase
    end

endmodule

// File: hdl/ex_hilo_unit.sv
`timescale 1ns/1ps

module ex_hilo_unit (
    input  ex_pkg::ex_issue_t         issue_i,
    input  ex_pkg::hilo_wr_t          mem_hilo_i,
    input  ex_pkg::hilo_wr_t          wb_hilo_i,
    input  ex_pkg::hilo_u             hilo_q_i,
    output logic [ex_pkg::DATA_W-1:0] move_wdata_o,
    output ex_pkg::hilo_wr_t          hilo_wr_o
);
    import ex_pkg::*;

    hilo_u               hilo_cur;   // newest hi/lo seen from execute
    logic                is_mult;
    logic [DATA_W-1:0]   op1_mag;
    logic [DATA_W-1:0]   op2_mag;
    logic [2*DATA_W-1:0] prod_mag;
    logic [2*DATA_W-1:0] mul_res;

    // mem is younger than wb, wb younger than the register
    always_comb begin
        if (mem_hilo_i.we) begin
            hilo_cur = mem_hilo_i.val;
        end else if (wb_hilo_i.we) begin
            hilo_cur = wb_hilo_i.val;
        end else begin
            hilo_cur = hilo_q_i;
        end
    end

    assign is_mult = (issue_i.aluop == OP_MULT);

    // signed mult works on magnitudes
    assign op1_mag  = (is_mult && issue_i.reg1[DATA_W-1]) ? (~issue_i.reg1 + 1'b1) : issue_i.reg1;
    assign op2_mag  = (is_mult && issue_i.reg2[DATA_W-1]) ? (~issue_i.reg2 + 1'b1) : issue_i.reg2;
    assign prod_mag = op1_mag * op2_mag;
    assign mul_res  = (is_mult && (issue_i.reg1[DATA_W-1] ^ issue_i.reg2[DATA_W-1])) ?
                      (~prod_mag + 1'b1) : prod_mag;

    always_comb begin
        case (issue_i.aluop)
            OP_MFHI: move_wdata_o = hilo_cur.hl.hi;
            OP_MFLO: move_wdata_o = hilo_cur.hl.lo;
            default: move_wdata_o = '0;
        endcase
    end

    always_comb begin
        hilo_wr_o = '0;
        case (issue_i.aluop)
            OP_MULT, OP_MULTU: begin
                hilo_wr_o.we       = 1'b1;
                hilo_wr_o.val.prod = mul_res;
            end
            OP_MTHI: begin
                hilo_wr_o.we        = 1'b1;
                hilo_wr_o.val.hl.hi = issue_i.reg1;
                hilo_wr_o.val.hl.lo = hilo_cur.hl.lo;   // lo kept
            end
            OP_MTLO: begin
                hilo_wr_o.we        = 1'b1;
                hilo_wr_o.val.hl.hi = hilo_cur.hl.hi;   // hi kept
                hilo_wr_o.val.hl.lo = issue_i.reg1;
            end
            default: begin
                hilo_wr_o = '0;
            end
        endcase
    end

endmodule

// File: hdl/ex_pipe.sv
`timescale 1ns/1ps

module ex_pipe (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  ex_pkg::ex_result_t ex_res_i,
    input  ex_pkg::hilo_wr_t   ex_hilo_i,
    output ex_pkg::hilo_wr_t   mem_hilo_o,
    output ex_pkg::hilo_wr_t   wb_hilo_o,
    output ex_pkg::hilo_u      hilo_q_o,
    output ex_pkg::ex_result_t result_o,
    output logic               ov_commit_o,
    output logic               trap_commit_o
);
    import ex_pkg::*;

    ex_stage_t mem_q;   // one edge after issue
    ex_stage_t wb_q;    // two edges after issue
    hilo_u     hilo_q;

    // no stalls, both stages advance every cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_q <= '0;
            wb_q  <= '0;
        end else begin
            mem_q.res  <= ex_res_i;
            mem_q.hilo <= ex_hilo_i;
            wb_q       <= mem_q;
        end
    end

    // hi/lo written as the item leaves wb
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hilo_q <= '0;
        end else if (wb_hilo_o.we) begin
            hilo_q <= wb_hilo_o.val;
        end
    end

    // write requests only count for a valid item
    always_comb begin
        mem_hilo_o.we  = mem_q.res.valid && mem_q.hilo.we;
        mem_hilo_o.val = mem_q.hilo.val;
        wb_hilo_o.we   = wb_q.res.valid && wb_q.hilo.we;
        wb_hilo_o.val  = wb_q.hilo.val;
    end

    assign hilo_q_o = hilo_q;
    assign result_o = wb_q.res;

    // one pulse per committed exception, counted in the csr block
    assign ov_commit_o   = wb_q.res.valid && wb_q.res.exc.ov;
    assign trap_commit_o = wb_q.res.valid && wb_q.res.exc.trap;

endmodule

// File: hdl/ex_csr.sv
`timescale 1ns/1ps

module ex_csr (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  ex_pkg::apb_req_t apb_i,
    output ex_pkg::apb_rsp_t apb_o,
    input  logic             ov_commit_i,
    input  logic             trap_commit_i,
    output ex_pkg::ex_cfg_t  cfg_o
);
    import ex_pkg::*;

    localparam int NEXC = $bits(exc_t);

    ex_cfg_t                     ctrl_q;
    logic [NEXC-1:0][CNT_W-1:0]  cnt_q;     // 0 ov, 1 trap
    logic [NEXC-1:0]             commit;
    logic [NEXC-1:0]             clr;
    logic                        acc;
    logic                        wr;
    logic                        rd;
    logic                        hit;
    logic [DATA_W-1:0]           rdata;

    // access phase of a transfer, setup phase does nothing
    assign acc = apb_i.psel && apb_i.penable;
    assign wr  = acc && apb_i.pwrite;
    assign rd  = acc && !apb_i.pwrite;

    assign commit = {trap_commit_i, ov_commit_i};
    assign clr    = (wr && apb_i.paddr == CSR_CLR) ? apb_i.pwdata[NEXC-1:0] : '0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q <= CSR_CTRL_RST;
        end else if (wr && apb_i.paddr == CSR_CTRL) begin
            ctrl_q <= apb_i.pwdata[1:0];
        end
    end

    // saturating, clear wins over a same cycle increment
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else begin
            for (int k = 0; k < NEXC; k++) begin
                if (clr[k]) begin
                    cnt_q[k] <= '0;
                end else if (commit[k] && cnt_q[k] != '1) begin
                    cnt_q[k] <= cnt_q[k] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (apb_i.paddr)
            CSR_CTRL:     rdata = {{(DATA_W-2){1'b0}}, ctrl_q};
            CSR_OV_CNT:   rdata = {{(DATA_W-CNT_W){1'b0}}, cnt_q[0]};
            CSR_TRAP_CNT: rdata = {{(DATA_W-CNT_W){1'b0}}, cnt_q[1]};
            CSR_CLR:      rdata = '0;    // write only, reads as zero
            default:      hit   = 1'b0;
        endcase
    end

    assign apb_o.prdata  = rdata;
    assign apb_o.pready  = 1'b1;           // never waits
    assign apb_o.pslverr = rd && !hit;     // unmapped read

    assign cfg_o = ctrl_q;

endmodule

// File: hdl/ex_top.sv
`timescale 1ns/1ps

module ex_top (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               issue_valid_i,
    input  ex_pkg::ex_issue_t  issue_i,
    output ex_pkg::ex_result_t result_o,
    input  ex_pkg::apb_req_t   apb_i,
    output ex_pkg::apb_rsp_t   apb_o
);
    import ex_pkg::*;

    ex_cfg_t           cfg;
    logic [DATA_W-1:0] alu_wdata;
    logic              alu_wreg;
    exc_t              alu_exc;
    logic [DATA_W-1:0] move_wdata;
    hilo_wr_t          ex_hilo;
    hilo_wr_t          mem_hilo;
    hilo_wr_t          wb_hilo;
    hilo_u             hilo_q;
    ex_result_t        ex_res;
    logic              ov_commit;
    logic              trap_commit;

    ex_alu u_alu (
        .issue_i (issue_i),
        .cfg_i   (cfg),
        .wdata_o (alu_wdata),
        .wreg_o  (alu_wreg),
        .exc_o   (alu_exc)
    );

    ex_hilo_unit u_hilo (
        .issue_i      (issue_i),
        .mem_hilo_i   (mem_hilo),
        .wb_hilo_i    (wb_hilo),
        .hilo_q_i     (hilo_q),
        .move_wdata_o (move_wdata),
        .hilo_wr_o    (ex_hilo)
    );

    // stage word entering mem
    always_comb begin
        ex_res.valid = issue_valid_i;
        ex_res.wd    = issue_i.wd;
        ex_res.wreg  = alu_wreg;
        ex_res.wdata = (issue_i.alusel == SEL_MOVE) ? move_wdata : alu_wdata;  // mfhi/mflo
        ex_res.exc   = alu_exc;
    end

    ex_pipe u_pipe (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .ex_res_i      (ex_res),
        .ex_hilo_i     (ex_hilo),
        .mem_hilo_o    (mem_hilo),
        .wb_hilo_o     (wb_hilo),
        .hilo_q_o      (hilo_q),
        .result_o      (result_o),
        .ov_commit_o   (ov_commit),
        .trap_commit_o (trap_commit)
    );

    ex_csr u_csr (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .apb_i         (apb_i),
        .apb_o         (apb_o),
        .ov_commit_i   (ov_commit),
        .trap_commit_i (trap_commit),
        .cfg_o         (cfg)
    );

endmodule

// File: sim/ex_tb.sv
`timescale 1ns/1ps

module ex_tb;
    import ex_pkg::*;

    localparam int DRV_DLY       = 1;    // input drive after the rising edge
    localparam int SMP_DLY       = 2;    // output sample after the rising edge
    localparam int DRAIN_TIMEOUT = 20;   // cycles
    localparam int APB_TIMEOUT   = 8;    // cycles

    // one expected result, due marks the edge it must show up at
    typedef struct packed {
        logic [REG_ADDR_W-1:0] wd;
        logic                  wreg;
        logic [DATA_W-1:0]     wdata;
        logic                  ov;
        logic                  trap;
        logic [31:0]           due;
    } expect_t;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       issue_valid;
    ex_issue_t  issue;
    ex_result_t result;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;

    logic [31:0] edge_cnt  = '0;
    logic [31:0] lcg_state = 32'd34;
    expect_t     exp_q[$];          // pending results, oldest first

    // case file fields
    integer           fd;
    integer           n;
    logic [63:0]      tok;
    logic [8*160-1:0] line_buf;
    logic [31:0]      f_aluop;
    logic [31:0]      f_alusel;
    logic [31:0]      f_reg1;
    logic [31:0]      f_reg2;
    logic [31:0]      f_wd;
    logic [31:0]      f_wreg;
    logic [31:0]      f_wdata;
    logic [31:0]      f_ewreg;
    logic [31:0]      f_ov;
    logic [31:0]      f_trap;
    logic [31:0]      rd_data;
    logic             rd_err;
    ex_issue_t        op;
    expect_t          want;

    ex_top DUT (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .result_o      (result),
        .apb_i         (apb_req),
        .apb_o         (apb_rsp)
    );

    always #2 clk = ~clk;   // 4 ns period

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            report_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // plain lcg, seed 34
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // compare a valid result with the oldest pending one
    task automatic check_result();
        expect_t e;
        assert (exp_q.size() != 0) else begin
            report_failure("a valid result appeared with no issue pending");
        end
        e = exp_q.pop_front();
        check_value("result_o.valid edge", edge_cnt, e.due);
        check_value("result_o.wd", result.wd, e.wd);
        check_value("result_o.wreg", result.wreg, e.wreg);
        check_value("result_o.wdata", result.wdata, e.wdata);
        check_value("result_o.exc.ov", result.exc.ov, e.ov);
        check_value("result_o.exc.trap", result.exc.trap, e.trap);
    endtask

    always @(posedge clk) begin
        #SMP_DLY;
        if (result.valid) begin
            check_result();
        end
    end

    task automatic drive_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #DRV_DLY;
            issue_valid = 1'b0;
            issue       = '0;
        end
    endtask

    task automatic send_issue(input ex_issue_t o, input expect_t w);
        expect_t e;
        e = w;
        @(posedge clk);
        #DRV_DLY;
        issue_valid = 1'b1;
        issue       = o;
        e.due       = edge_cnt + 2;   // two edges later on result_o
        exp_q.push_back(e);
    endtask

    // all results out, then one more edge so the counters settle
    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0 && cnt < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        assert (exp_q.size() == 0) else begin
            report_failure("timeout while waiting for pending results");
        end
        @(posedge clk);
    endtask

    // setup then access, held until pready
    task automatic apb_transfer(input logic wr, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int   cnt;
        logic done;
        cnt   = 0;
        done  = 1'b0;
        rdata = '0;
        err   = 1'b0;
        @(posedge clk);
        #DRV_DLY;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #DRV_DLY;
        apb_req.penable = 1'b1;
        while (!done && cnt < APB_TIMEOUT) begin
            #(SMP_DLY - DRV_DLY);
            if (apb_rsp.pready) begin
                done  = 1'b1;
                rdata = apb_rsp.prdata;
                err   = apb_rsp.pslverr;
            end else begin
                @(posedge clk);
                #DRV_DLY;
                cnt++;
            end
        end
        assert (done) else begin
            report_failure("timeout while waiting for pready");
        end
        @(posedge clk);   // transfer completes here
        #DRV_DLY;
        apb_req = '0;
    endtask

    initial begin
        arst_n      = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        apb_req     = '0;
        fd = $fopen("sim/ex_cases.txt", "r");
        assert (fd != 0) else begin
            report_failure("cannot open sim/ex_cases.txt");
        end
        repeat (8) @(posedge clk);
        #DRV_DLY;
        arst_n = 1'b1;

        while (!$feof(fd)) begin
            n = $fscanf(fd, " %s", tok);
            if (n != 1) begin
                break;
            end
            if (tok == "#") begin
                n = $fgets(line_buf, fd);   // comment line
            end else if (tok == "I" || tok == "J") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", f_aluop, f_alusel,
                            f_reg1, f_reg2, f_wd, f_wreg, f_wdata, f_ewreg, f_ov, f_trap);
                assert (n == 10) else begin
                    report_failure("malformed issue line in the case file");
                end
                op.aluop   = aluop_e'(f_aluop[7:0]);
                op.alusel  = alusel_e'(f_alusel[2:0]);
                op.reg1    = f_reg1;
                op.reg2    = f_reg2;
                op.wd      = f_wd[REG_ADDR_W-1:0];
                op.wreg    = f_wreg[0];
                want.wd    = f_wd[REG_ADDR_W-1:0];
                want.wreg  = f_ewreg[0];
                want.wdata = f_wdata;
                want.ov    = f_ov[0];
                want.trap  = f_trap[0];
                want.due   = '0;
                if (tok == "I") begin
                    drive_idle(lcg_next() >> 16 & 32'd3);   // 0..3 idle cycles
                end
                send_issue(op, want);
            end else if (tok == "R" || tok == "W") begin
                n = $fscanf(fd, "%h %h", f_reg1, f_reg2);
                if (tok == "R") begin
                    n = n + $fscanf(fd, "%h", f_trap);
                end
                assert (n == ((tok == "R") ? 3 : 2)) else begin
                    report_failure("malformed apb line in the case file");
                end
                drive_idle(1);
                wait_drain();
                if (tok == "R") begin
                    apb_transfer(1'b0, f_reg1[7:0], '0, rd_data, rd_err);
                    check_value("apb_o.prdata", rd_data, f_reg2);
                    check_value("apb_o.pslverr", rd_err, f_trap);
                end else begin
                    apb_transfer(1'b1, f_reg1[7:0], f_reg2, rd_data, rd_err);
                    check_value("apb_o.pslverr", rd_err, 32'd0);
                end
            end else begin
                report_failure("unknown line kind in the case file");
            end
        end

        drive_idle(1);
        wait_drain();
        $fclose(fd);
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: all.f
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_hilo_unit.sv
hdl/ex_pipe.sv
hdl/ex_csr.sv
hdl/ex_top.sv
sim/ex_tb.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - hdl/ex_pkg.sv
      - hdl/ex_alu.sv
      - hdl/ex_hilo_unit.sv
      - hdl/ex_pipe.sv
      - hdl/ex_csr.sv
      - hdl/ex_top.sv
  - target: simulation
    files:
      - sim/ex_tb.sv

// File: sim/ex_cases.txt
# R addr exp_prdata exp_pslverr | W addr pwdata
# I (random gap) or J (no gap): aluop alusel reg1 reg2 wd wreg exp_wdata exp_wreg exp_ov exp_trap
R 00 00000003 0
R 04 00000000 0
R 08 00000000 0
R 10 00000000 1
I 25 1 f0f00000 0000ff00 01 1 f0f0ff00 1 0 0
I 24 1 ffff0000 12345678 02 1 12340000 1 0 0
I 27 1 f0f0f0f0 0f0f0000 03 1 00000f0f 1 0 0
I 26 1 aaaa5555 ffff0000 04 1 55555555 1 0 0
I 7c 2 00000004 00000001 05 1 00000010 1 0 0
I 02 2 00000008 80000000 06 1 00800000 1 0 0
J 03 2 00000008 80000000 07 1 ff800000 1 0 0
I 03 2 0000001f f0000000 08 1 ffffffff 1 0 0
I 21 4 ffffffff 00000001 09 1 00000000 1 0 0
I 20 4 00000005 fffffffd 0a 1 00000002 1 0 0
I 23 4 00000003 00000005 0b 1 fffffffe 1 0 0
J 22 4 00000010 00000004 0c 1 0000000c 1 0 0
I 56 4 00001000 ffffffff 0d 1 00000fff 1 0 0
I 2a 4 ffffffff 00000001 0e 1 00000001 1 0 0
J 2b 4 ffffffff 00000001 0f 1 00000000 1 0 0
I 2a 4 00000001 ffffffff 10 1 00000000 1 0 0
J 2b 4 00000001 ffffffff 11 1 00000001 1 0 0
I b0 4 00000000 00000000 12 1 00000020 1 0 0
I b0 4 ffffffff 00000000 13 1 00000000 1 0 0
I b1 4 ffffffff 00000000 14 1 00000020 1 0 0
J b1 4 00000000 00000000 15 1 00000000 1 0 0
I b0 4 00010000 00000000 16 1 0000000f 1 0 0
I 20 4 7fffffff 00000001 17 1 80000000 0 1 0
I 22 4 80000000 00000001 18 1 7fffffff 0 1 0
J 55 4 7ffffff0 00000010 19 1 80000000 0 1 0
I 34 0 00000007 00000007 00 0 00000000 0 0 1
I 36 0 00000007 00000007 00 0 00000000 0 0 0
I 32 0 ffffffff 00000001 00 0 00000000 0 0 1
J 33 0 ffffffff 00000001 00 0 00000000 0 0 0
I 31 0 ffffffff 00000001 00 1 00000000 1 0 1
I 44 0 00000003 fffffffd 00 0 00000000 0 0 1
I 49 0 00000004 00000004 00 0 00000000 0 0 0
R 04 00000003 0
R 08 00000004 0
W 00 00000000
I 20 4 7fffffff 00000001 1a 1 80000000 1 0 0
J 34 0 00000001 00000001 00 0 00000000 0 0 0
R 04 00000003 0
R 08 00000004 0
R 00 00000000 0
W 0c 00000003
R 04 00000000 0
R 08 00000000 0
W 00 00000003
R 00 00000003 0
I 18 0 fffffffe 00000003 00 0 00000000 0 0 0
J 10 3 00000000 00000000 01 1 ffffffff 1 0 0
J 12 3 00000000 00000000 02 1 fffffffa 1 0 0
I 19 0 fffffffe 00000003 00 0 00000000 0 0 0
J 10 3 00000000 00000000 03 1 00000002 1 0 0
J 12 3 00000000 00000000 04 1 fffffffa 1 0 0
I 11 0 12345678 00000000 00 0 00000000 0 0 0
J 12 3 00000000 00000000 05 1 fffffffa 1 0 0
J 10 3 00000000 00000000 06 1 12345678 1 0 0
I 13 0 9abcdef0 00000000 00 0 00000000 0 0 0
J 12 3 00000000 00000000 07 1 9abcdef0 1 0 0
J 10 3 00000000 00000000 08 1 12345678 1 0 0
I 18 0 80000000 80000000 00 0 00000000 0 0 0
I 10 3 00000000 00000000 09 1 40000000 1 0 0
I 12 3 00000000 00000000 0a 1 00000000 1 0 0
I 19 0 ffffffff ffffffff 00 0 00000000 0 0 0
I 10 3 00000000 00000000 0b 1 fffffffe 1 0 0
I 12 3 00000000 00000000 0c 1 00000001 1 0 0
I 18 0 00000007 fffffff9 00 0 00000000 0 0 0
I 12 3 00000000 00000000 0d 1 ffffffcf 1 0 0
I 10 3 00000000 00000000 0e 1 ffffffff 1 0 0
I 13 0 00000055 00000000 00 0 00000000 0 0 0
I 10 3 00000000 00000000 0f 1 ffffffff 1 0 0
I 12 3 00000000 00000000 10 1 00000055 1 0 0
I 11 0 00000066 00000000 00 0 00000000 0 0 0
I 10 3 00000000 00000000 11 1 00000066 1 0 0
